/* design/mips_decode.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_decode (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic [`MIPS_XLEN-1:0]      i_ifid_instr,
    input  logic [`MIPS_XLEN-1:0]      i_ifid_pc4,
    input  mips_pkg::wb_t              i_wb,
    input  logic                       i_ex_is_load,
    input  logic [`MIPS_REG_BITS-1:0]  i_ex_load_rt,
    input  logic                       i_flush,
    input  logic [`MIPS_REG_BITS-1:0]  i_dbg_reg_addr,
    output mips_pkg::id_ex_t           o_id_ex,
    output logic                       o_stall,
    output logic [`MIPS_XLEN-1:0]      o_dbg_reg_data
);

    logic [`MIPS_XLEN-1:0]     regs [2**`MIPS_REG_BITS];
    mips_pkg::opcode_e         op;
    logic [5:0]                funct;
    logic [`MIPS_REG_BITS-1:0] rs_idx;
    logic [`MIPS_REG_BITS-1:0] rt_idx;
    logic [`MIPS_REG_BITS-1:0] rd_idx;
    logic [`MIPS_XLEN-1:0]     imm_ext;
    logic [`MIPS_XLEN-1:0]     rs_val;
    logic [`MIPS_XLEN-1:0]     rt_val;
    mips_pkg::ctrl_t           ctrl;
    mips_pkg::alu_op_e         alu_op;
    logic                      rf_we;
    logic                      uses_rt;
    logic                      load_use;
    logic                      halted_q;

    assign op      = mips_pkg::opcode_e'(i_ifid_instr[31:26]);
    assign rs_idx  = i_ifid_instr[25:21];
    assign rt_idx  = i_ifid_instr[20:16];
    assign rd_idx  = i_ifid_instr[15:11];
    assign funct   = i_ifid_instr[5:0];
    assign imm_ext = {{16{i_ifid_instr[15]}}, i_ifid_instr[15:0]};

    always_comb begin
        ctrl   = '0;
        alu_op = mips_pkg::ALU_ADD;
        case (op)
            mips_pkg::OP_RTYPE: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst_rd = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    `MIPS_FN_AND:  alu_op = mips_pkg::ALU_AND;
                    `MIPS_FN_OR:   alu_op = mips_pkg::ALU_OR;
                    `MIPS_FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    default:       ctrl   = '0;
                endcase
            end
            mips_pkg::OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mips_pkg::OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                ctrl.branch = 1'b1;
                alu_op      = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_HALT: ctrl.halt = 1'b1;
            default:           ctrl      = '0;
        endcase
    end

    // Register file with write-through on read
    assign rf_we = i_wb.we && (i_wb.addr != '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**`MIPS_REG_BITS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    assign rs_val         = (rf_we && i_wb.addr == rs_idx) ? i_wb.data : regs[rs_idx];
    assign rt_val         = (rf_we && i_wb.addr == rt_idx) ? i_wb.data : regs[rt_idx];
    assign o_dbg_reg_data = regs[i_dbg_reg_addr];

    // rt is a source for R-type, beq and sw
    assign uses_rt  = !ctrl.alu_src || ctrl.mem_write;
    assign load_use = i_ex_is_load && (i_ex_load_rt != '0) &&
                      ((i_ex_load_rt == rs_idx) || (uses_rt && i_ex_load_rt == rt_idx));
    assign o_stall  = load_use || halted_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            halted_q <= 1'b0;
        end else if (ctrl.halt && !o_stall) begin
            halted_q <= 1'b1;
        end
    end

    // ID/EX register, bubble on stall or flush
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush || o_stall) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.ctrl   <= ctrl;
            o_id_ex.alu_op <= alu_op;
            o_id_ex.pc4    <= i_ifid_pc4;
            o_id_ex.rs_val <= rs_val;
            o_id_ex.rt_val <= rt_val;
            o_id_ex.imm    <= imm_ext;
            o_id_ex.rs     <= rs_idx;
            o_id_ex.rt     <= rt_idx;
            o_id_ex.rd     <= rd_idx;
        end
    end

    // Writeback stage must never target r0
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb.we |-> (i_wb.addr != '0));

endmodule

/* design/mips_execute.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_execute (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  mips_pkg::id_ex_t           i_id_ex,
    input  mips_pkg::wb_t              i_memwb_fwd,
    input  logic                       i_flush,
    output mips_pkg::ex_mem_t          o_ex_mem,
    output logic                       o_ex_is_load,
    output logic [`MIPS_REG_BITS-1:0]  o_ex_load_rt
);

    mips_pkg::fwd_sel_e        sel_a;
    mips_pkg::fwd_sel_e        sel_b;
    logic [`MIPS_XLEN-1:0]     op_a;
    logic [`MIPS_XLEN-1:0]     rt_fwd;
    logic [`MIPS_XLEN-1:0]     op_b;
    logic [`MIPS_XLEN-1:0]     alu_res;
    logic [`MIPS_XLEN-1:0]     br_target;
    logic [`MIPS_REG_BITS-1:0] dst;

    // EX/MEM wins over MEM/WB and r0 never forwards
    function automatic mips_pkg::fwd_sel_e pick_src(input logic [`MIPS_REG_BITS-1:0] idx,
                                                    input mips_pkg::ex_mem_t exmem,
                                                    input mips_pkg::wb_t memwb);
        if (exmem.ctrl.reg_write && exmem.dst != '0 && exmem.dst == idx) begin
            return mips_pkg::FWD_EXMEM;
        end else if (memwb.we && memwb.addr != '0 && memwb.addr == idx) begin
            return mips_pkg::FWD_MEMWB;
        end
        return mips_pkg::FWD_REG;
    endfunction

    function automatic logic [`MIPS_XLEN-1:0] fwd_value(input mips_pkg::fwd_sel_e sel,
                                                       input logic [`MIPS_XLEN-1:0] reg_val,
                                                       input logic [`MIPS_XLEN-1:0] exmem_val,
                                                       input logic [`MIPS_XLEN-1:0] memwb_val);
        case (sel)
            mips_pkg::FWD_EXMEM: return exmem_val;
            mips_pkg::FWD_MEMWB: return memwb_val;
            default:             return reg_val;
        endcase
    endfunction

    assign sel_a  = pick_src(i_id_ex.rs, o_ex_mem, i_memwb_fwd);
    assign sel_b  = pick_src(i_id_ex.rt, o_ex_mem, i_memwb_fwd);
    assign op_a   = fwd_value(sel_a, i_id_ex.rs_val, o_ex_mem.alu_res, i_memwb_fwd.data);
    assign rt_fwd = fwd_value(sel_b, i_id_ex.rt_val, o_ex_mem.alu_res, i_memwb_fwd.data);
    assign op_b   = i_id_ex.ctrl.alu_src ? i_id_ex.imm : rt_fwd;

    always_comb begin
        case (i_id_ex.alu_op)
            mips_pkg::ALU_SUB: alu_res = op_a - op_b;
            mips_pkg::ALU_AND: alu_res = op_a & op_b;
            mips_pkg::ALU_OR:  alu_res = op_a | op_b;
            mips_pkg::ALU_SLT: alu_res = {{(`MIPS_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:           alu_res = op_a + op_b;
        endcase
    end

    assign br_target = i_id_ex.pc4 + {i_id_ex.imm[`MIPS_XLEN-3:0], 2'b00};
    assign dst       = i_id_ex.ctrl.reg_dst_rd ? i_id_ex.rd : i_id_ex.rt;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.ctrl       <= i_id_ex.ctrl;
            o_ex_mem.br_target  <= br_target;
            o_ex_mem.zero       <= (alu_res == '0);
            o_ex_mem.alu_res    <= alu_res;
            o_ex_mem.store_data <= rt_fwd;
            o_ex_mem.dst        <= dst;
        end
    end

    // For load-use detection in decode
    assign o_ex_is_load = i_id_ex.ctrl.mem_read;
    assign o_ex_load_rt = i_id_ex.rt;

    // A taken branch leaves a bubble behind it
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> (o_ex_mem == '0));

endmodule

/* design/mips_fetch.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_fetch (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_imem_we,
    input  logic [`MIPS_IMEM_ABITS-1:0] i_imem_addr,
    input  logic [`MIPS_XLEN-1:0]       i_imem_data,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic [`MIPS_XLEN-1:0]       i_branch_target,
    output logic [`MIPS_XLEN-1:0]       o_pc,
    output logic [`MIPS_XLEN-1:0]       o_ifid_instr,
    output logic [`MIPS_XLEN-1:0]       o_ifid_pc4
);

    logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_DEPTH];
    logic [`MIPS_XLEN-1:0] pc_q;
    logic [`MIPS_XLEN-1:0] pc4;
    logic [`MIPS_XLEN-1:0] instr;

    // Loaded externally, kept across reset
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    assign pc4   = pc_q + `MIPS_XLEN'(4);
    assign instr = imem[pc_q[`MIPS_IMEM_ABITS+1:2]];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q <= '0;
        end else if (i_flush) begin
            pc_q <= i_branch_target;
        end else if (!i_stall) begin
            pc_q <= pc4;
        end
    end

    // IF/ID register, cleared word decodes as a nop
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            o_ifid_instr <= '0;
            o_ifid_pc4   <= '0;
        end else if (!i_stall) begin
            o_ifid_instr <= instr;
            o_ifid_pc4   <= pc4;
        end
    end

    assign o_pc = pc_q;

    // Stall from decode freezes the PC
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stall && !i_flush |=> $stable(o_pc));

endmodule

/* design/mips_memory.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_memory (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  mips_pkg::ex_mem_t           i_ex_mem,
    input  logic [`MIPS_DMEM_ABITS-1:0] i_dbg_mem_addr,
    output logic                        o_branch_taken,
    output logic [`MIPS_XLEN-1:0]       o_branch_target,
    output mips_pkg::wb_t               o_wb,
    output logic [`MIPS_XLEN-1:0]       o_dbg_mem_data,
    output logic                        o_halt
);

    logic [`MIPS_XLEN-1:0]       dmem [`MIPS_DMEM_DEPTH];
    logic [`MIPS_DMEM_ABITS-1:0] daddr;
    logic [`MIPS_XLEN-1:0]       load_data;
    mips_pkg::mem_wb_t           mem_wb_q;
    logic                        halt_q;

    assign daddr = i_ex_mem.alu_res[`MIPS_DMEM_ABITS+1:2];

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.ctrl.mem_write) begin
            dmem[daddr] <= i_ex_mem.store_data;
        end
    end

    assign load_data      = dmem[daddr];
    assign o_dbg_mem_data = dmem[i_dbg_mem_addr];

    // beq resolves here
    assign o_branch_taken  = i_ex_mem.ctrl.branch && i_ex_mem.zero;
    assign o_branch_target = i_ex_mem.br_target;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.reg_write  <= i_ex_mem.ctrl.reg_write;
            mem_wb_q.mem_to_reg <= i_ex_mem.ctrl.mem_to_reg;
            mem_wb_q.halt       <= i_ex_mem.ctrl.halt;
            mem_wb_q.alu_res    <= i_ex_mem.alu_res;
            mem_wb_q.load_data  <= load_data;
            mem_wb_q.dst        <= i_ex_mem.dst;
        end
    end

    // Writeback select
    assign o_wb.we   = mem_wb_q.reg_write && (mem_wb_q.dst != '0);
    assign o_wb.addr = mem_wb_q.dst;
    assign o_wb.data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_res;

    // Sticky until reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            halt_q <= 1'b0;
        end else if (mem_wb_q.halt) begin
            halt_q <= 1'b1;
        end
    end

    assign o_halt = halt_q || mem_wb_q.halt;

endmodule

/* design/mips_pkg.sv */
`include "mips_defs.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = `MIPS_OP_RTYPE,
        OP_BEQ   = `MIPS_OP_BEQ,
        OP_ADDI  = `MIPS_OP_ADDI,
        OP_LW    = `MIPS_OP_LW,
        OP_SW    = `MIPS_OP_SW,
        OP_HALT  = `MIPS_OP_HALT
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // Operand source for forwarding
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic alu_src;
        logic branch;
        logic halt;
        logic reg_dst_rd;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        alu_op_e                   alu_op;
        logic [`MIPS_XLEN-1:0]     pc4;
        logic [`MIPS_XLEN-1:0]     rs_val;
        logic [`MIPS_XLEN-1:0]     rt_val;
        logic [`MIPS_XLEN-1:0]     imm;
        logic [`MIPS_REG_BITS-1:0] rs;
        logic [`MIPS_REG_BITS-1:0] rt;
        logic [`MIPS_REG_BITS-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        logic [`MIPS_XLEN-1:0]     br_target;
        logic                      zero;
        logic [`MIPS_XLEN-1:0]     alu_res;
        logic [`MIPS_XLEN-1:0]     store_data;
        logic [`MIPS_REG_BITS-1:0] dst;
    } ex_mem_t;

    typedef struct packed {
        logic                      reg_write;
        logic                      mem_to_reg;
        logic                      halt;
        logic [`MIPS_XLEN-1:0]     alu_res;
        logic [`MIPS_XLEN-1:0]     load_data;
        logic [`MIPS_REG_BITS-1:0] dst;
    } mem_wb_t;

    // Register write from writeback
    typedef struct packed {
        logic                      we;
        logic [`MIPS_REG_BITS-1:0] addr;
        logic [`MIPS_XLEN-1:0]     data;
    } wb_t;

endpackage

/* design/mips_top.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_imem_we,
    input  logic [`MIPS_IMEM_ABITS-1:0] i_imem_addr,
    input  logic [`MIPS_XLEN-1:0]       i_imem_data,
    input  logic [`MIPS_REG_BITS-1:0]   i_dbg_reg_addr,
    output logic [`MIPS_XLEN-1:0]       o_dbg_reg_data,
    input  logic [`MIPS_DMEM_ABITS-1:0] i_dbg_mem_addr,
    output logic [`MIPS_XLEN-1:0]       o_dbg_mem_data,
    output logic [`MIPS_XLEN-1:0]       o_pc,
    output logic                        o_halt
);

    logic [`MIPS_XLEN-1:0]     ifid_instr;
    logic [`MIPS_XLEN-1:0]     ifid_pc4;
    logic                      stall;
    logic                      branch_taken;
    logic [`MIPS_XLEN-1:0]     branch_target;
    logic                      ex_is_load;
    logic [`MIPS_REG_BITS-1:0] ex_load_rt;
    mips_pkg::id_ex_t          id_ex;
    mips_pkg::ex_mem_t         ex_mem;
    mips_pkg::wb_t             wb;

    mips_fetch u_fetch (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .i_stall         (stall),
        .i_flush         (branch_taken),
        .i_branch_target (branch_target),
        .o_pc            (o_pc),
        .o_ifid_instr    (ifid_instr),
        .o_ifid_pc4      (ifid_pc4)
    );

    mips_decode u_decode (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_ifid_instr    (ifid_instr),
        .i_ifid_pc4      (ifid_pc4),
        .i_wb            (wb),
        .i_ex_is_load    (ex_is_load),
        .i_ex_load_rt    (ex_load_rt),
        .i_flush         (branch_taken),
        .i_dbg_reg_addr  (i_dbg_reg_addr),
        .o_id_ex         (id_ex),
        .o_stall         (stall),
        .o_dbg_reg_data  (o_dbg_reg_data)
    );

    mips_execute u_execute (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_id_ex         (id_ex),
        .i_memwb_fwd     (wb),
        .i_flush         (branch_taken),
        .o_ex_mem        (ex_mem),
        .o_ex_is_load    (ex_is_load),
        .o_ex_load_rt    (ex_load_rt)
    );

    mips_memory u_memory (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_ex_mem        (ex_mem),
        .i_dbg_mem_addr  (i_dbg_mem_addr),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target),
        .o_wb            (wb),
        .o_dbg_mem_data  (o_dbg_mem_data),
        .o_halt          (o_halt)
    );

endmodule

/* include/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath and register index widths
`define MIPS_XLEN           32
`define MIPS_REG_BITS       5

// Word-addressed memories
`define MIPS_IMEM_DEPTH     256
`define MIPS_IMEM_ABITS     8
`define MIPS_DMEM_DEPTH     256
`define MIPS_DMEM_ABITS     8

// Opcodes
`define MIPS_OP_RTYPE       6'd0
`define MIPS_OP_BEQ         6'd4
`define MIPS_OP_ADDI        6'd8
`define MIPS_OP_LW          6'd35
`define MIPS_OP_SW          6'd43
`define MIPS_OP_HALT        6'd63

// R-type funct codes
`define MIPS_FN_ADDU        6'd33
`define MIPS_FN_SUBU        6'd35
`define MIPS_FN_AND         6'd36
`define MIPS_FN_OR          6'd37
`define MIPS_FN_SLT         6'd42

`endif

/* mips_pipe.f */
+incdir+include
design/mips_pkg.sv
design/mips_fetch.sv
design/mips_decode.sv
design/mips_execute.sv
design/mips_memory.sv
design/mips_top.sv
verif/tb_mips_pipe.sv

/* verif/mips_stimulus.txt */
# P starts a test, E ends it. I: imem word address, instruction word (hex)
# R: register index, expected value (hex). M: dmem word address, expected value (hex)
P
I 00 20010005 # addi r1, r0, 5
I 01 20220003 # addi r2, r1, 3
I 02 00221821 # addu r3, r1, r2
I 03 00612023 # subu r4, r3, r1
I 04 00832824 # and  r5, r4, r3
I 05 00a13025 # or   r6, r5, r1
I 06 0026382a # slt  r7, r1, r6
I 07 2008ffff # addi r8, r0, -1
I 08 0101482a # slt  r9, r8, r1
I 09 fc000000 # halt
R 01 00000005
R 02 00000008
R 03 0000000d
R 04 00000008
R 05 00000008
R 06 0000000d
R 07 00000001
R 08 ffffffff
R 09 00000001
E
P
I 00 20010055 # addi r1, r0, 0x55
I 01 20020123 # addi r2, r0, 0x123
I 02 ac010000 # sw   r1, 0(r0)
I 03 ac020004 # sw   r2, 4(r0)
I 04 8c030004 # lw   r3, 4(r0)
I 05 00612021 # addu r4, r3, r1
I 06 8c050000 # lw   r5, 0(r0)
I 07 ac050008 # sw   r5, 8(r0)
I 08 fc000000 # halt
R 03 00000123
R 04 00000178
R 05 00000055
M 00 00000055
M 01 00000123
M 02 00000055
E
P
I 00 20010007 # addi r1, r0, 7
I 01 20020007 # addi r2, r0, 7
I 02 10220003 # beq  r1, r2, +3 taken
I 03 20030001 # addi r3, r0, 1 skipped
I 04 20040001 # addi r4, r0, 1 skipped
I 05 20050001 # addi r5, r0, 1 skipped
I 06 10200001 # beq  r1, r0, +1 not taken
I 07 20060009 # addi r6, r0, 9
I 08 fc000000 # halt
I 09 20070001 # addi r7, r0, 1 after halt
R 01 00000007
R 03 00000000
R 04 00000000
R 05 00000000
R 06 00000009
R 07 00000000
E

/* verif/tb_mips_pipe.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_mips_pipe;

    localparam int CLK_HALF         = 10;
    localparam int RST_CYCLES       = 5;
    localparam int CYCLES_PER_INSTR = 40;
    localparam int HOLD_CYCLES      = 4;

    logic                        clk;
    logic                        rst_n;
    logic                        imem_we;
    logic [`MIPS_IMEM_ABITS-1:0] imem_addr;
    logic [`MIPS_XLEN-1:0]       imem_data;
    logic [`MIPS_REG_BITS-1:0]   dbg_reg_addr;
    logic [`MIPS_XLEN-1:0]       dbg_reg_data;
    logic [`MIPS_DMEM_ABITS-1:0] dbg_mem_addr;
    logic [`MIPS_XLEN-1:0]       dbg_mem_data;
    logic [`MIPS_XLEN-1:0]       pc;
    logic                        halt;

    // Parsed stimulus records with one entry per tag
    logic [7:0]            rec_tag [$];
    logic [`MIPS_XLEN-1:0] rec_a [$];
    logic [`MIPS_XLEN-1:0] rec_b [$];

    int mismatch_count;
    int other_count;
    int watchdog_cycles;

    mips_top UUT (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_imem_we      (imem_we),
        .i_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .i_dbg_reg_addr (dbg_reg_addr),
        .o_dbg_reg_data (dbg_reg_data),
        .i_dbg_mem_addr (dbg_mem_addr),
        .o_dbg_mem_data (dbg_mem_data),
        .o_pc           (pc),
        .o_halt         (halt)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at time %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_stimulus();
        int         fd;
        int         code;
        int         ch;
        logic [7:0] tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("verif/mips_stimulus.txt", "r");
        if (fd == 0) begin
            other_count++;
            $display("Could not open the stimulus file verif/mips_stimulus.txt");
        end else begin
            code = $fscanf(fd, " %c", tag);
            while (code == 1) begin
                if (tag == "#") begin
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (tag == "I" || tag == "R" || tag == "M") begin
                    if ($fscanf(fd, "%h %h", a, b) != 2) begin
                        other_count++;
                        $display("A stimulus line with tag %c has missing values", tag);
                    end
                    rec_tag.push_back(tag);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                end else if (tag == "P" || tag == "E") begin
                    rec_tag.push_back(tag);
                    rec_a.push_back('0);
                    rec_b.push_back('0);
                end else begin
                    other_count++;
                    $display("The stimulus file holds an unknown tag %c", tag);
                end
                code = $fscanf(fd, " %c", tag);
            end
            $fclose(fd);
        end
    endtask

    // All tasks below start and end just after a rising edge
    task automatic hold_reset();
        rst_n <= 1'b0;
        imem_we <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] word);
        imem_we   <= 1'b1;
        imem_addr <= addr[`MIPS_IMEM_ABITS-1:0];
        imem_data <= word;
        @(posedge clk);
    endtask

    task automatic check_register(input int test, input logic [31:0] idx,
                                  input logic [31:0] exp);
        dbg_reg_addr <= idx[`MIPS_REG_BITS-1:0];
        @(negedge clk);
        check_value($sformatf("test %0d register %0d", test, idx), dbg_reg_data, exp);
        @(posedge clk);
    endtask

    task automatic check_memory(input int test, input logic [31:0] addr,
                                input logic [31:0] exp);
        dbg_mem_addr <= addr[`MIPS_DMEM_ABITS-1:0];
        @(negedge clk);
        check_value($sformatf("test %0d memory word %0d", test, addr), dbg_mem_data, exp);
        @(posedge clk);
    endtask

    // Registers cleared and halt low while reset is held
    task automatic check_reset_state();
        hold_reset();
        @(negedge clk);
        check_value("halt after reset", {31'b0, halt}, 32'd0);
        @(posedge clk);
        for (int r = 0; r < 2**`MIPS_REG_BITS; r++) begin
            check_register(0, r, 32'd0);
        end
    endtask

    task automatic run_program(input int test, input int n_instr);
        int          cycles;
        logic [31:0] pc_at_halt;
        imem_we <= 1'b0;
        rst_n   <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!halt && cycles < n_instr * CYCLES_PER_INSTR) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            other_count++;
            $display("Test %0d: the program did not halt within %0d cycles", test, cycles);
        end else begin
            // PC frozen and halt sticky afterwards
            pc_at_halt = pc;
            repeat (HOLD_CYCLES) @(negedge clk);
            check_value($sformatf("test %0d PC after halt", test), pc, pc_at_halt);
            check_value($sformatf("test %0d halt flag", test), {31'b0, halt}, 32'd1);
        end
        @(posedge clk);
    endtask

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int n_instr;
        int n_tests;
        int n_checks;
        int test_instr;
        int test_num;
        bit ran;
        clk            = 1'b0;
        rst_n          = 1'b0;
        imem_we        = 1'b0;
        imem_addr      = '0;
        imem_data      = '0;
        dbg_reg_addr   = '0;
        dbg_mem_addr   = '0;
        mismatch_count = 0;
        other_count    = 0;
        n_instr        = 0;
        n_tests        = 0;
        n_checks       = 0;
        test_instr     = 0;
        test_num       = 0;
        ran            = 1'b1;
        watchdog_cycles = 0;
        read_stimulus();
        foreach (rec_tag[i]) begin
            if (rec_tag[i] == "I") n_instr++;
            if (rec_tag[i] == "P") n_tests++;
            if (rec_tag[i] == "R" || rec_tag[i] == "M") n_checks++;
        end
        watchdog_cycles = n_instr * CYCLES_PER_INSTR
                        + (n_tests + 1) * (RST_CYCLES + HOLD_CYCLES + 4)
                        + 2 * (n_checks + 2**`MIPS_REG_BITS);
        @(posedge clk);
        check_reset_state();
        foreach (rec_tag[i]) begin
            case (rec_tag[i])
                "P": begin
                    test_num++;
                    test_instr = 0;
                    ran = 1'b0;
                    hold_reset();
                end
                "I": begin
                    load_word(rec_a[i], rec_b[i]);
                    test_instr++;
                end
                default: begin
                    if (!ran) begin
                        run_program(test_num, test_instr);
                        ran = 1'b1;
                    end
                    if (rec_tag[i] == "R") begin
                        check_register(test_num, rec_a[i], rec_b[i]);
                    end else if (rec_tag[i] == "M") begin
                        check_memory(test_num, rec_a[i], rec_b[i]);
                    end
                end
            endcase
        end
        $display("Finished %0d tests: %0d mismatches, %0d other errors",
                 test_num, mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
